// File: hw/cache_pkg.sv
// data cache shared types
`default_nettype none

package cache_pkg;

    localparam int line_bytes = 16;
    localparam int num_sets   = 64;

    // address split: tag | index | offset
    localparam int offset_w = $clog2(line_bytes);
    localparam int index_w  = $clog2(num_sets);
    localparam int tag_w    = 32 - index_w - offset_w;

    typedef logic [31:0]             addr_t;
    typedef logic [31:0]             word_t;
    typedef logic [line_bytes*8-1:0] line_t;
    typedef logic [tag_w-1:0]        tag_t;
    typedef logic [index_w-1:0]      index_t;
    typedef logic [offset_w-1:0]     offset_t;
    typedef logic [1:0]              size_t;

    // access size codes
    localparam size_t size_word = 2'd0;
    localparam size_t size_byte = 2'd1;
    localparam size_t size_half = 2'd2;

endpackage

`default_nettype wire

// File: hw/cpu_req_port.sv
// cpu request capture
`timescale 1ns/1ps
`default_nettype none

module cpu_req_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cpu_valid,
    input  cache_pkg::addr_t    cpu_addr,
    input  cache_pkg::word_t    cpu_wdata,
    input  logic                cpu_write,
    input  cache_pkg::size_t    cpu_size,
    input  logic                req_clear,
    output logic                cpu_ready,
    output logic                req_start,
    output cache_pkg::tag_t     req_tag,
    output cache_pkg::index_t   req_index,
    output cache_pkg::offset_t  req_offset,
    output cache_pkg::word_t    req_wdata,
    output logic                req_write,
    output cache_pkg::size_t    req_size
);
    import cache_pkg::*;

    logic ready_q;  // no transaction held

    assign req_start = cpu_valid & cpu_ready;

    // ready returns in the done cycle, so a new request may follow back to back
    assign cpu_ready = ready_q | req_clear;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b1;
        end else if (req_start) begin
            ready_q <= 1'b0;  // busy until done
        end else if (req_clear) begin
            ready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_start) begin
            req_tag    <= cpu_addr[31 -: tag_w];
            req_index  <= cpu_addr[offset_w +: index_w];
            req_offset <= cpu_addr[offset_w-1:0];
            req_wdata  <= cpu_wdata;
            req_write  <= cpu_write;
            req_size   <= cpu_size;
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_way_array.sv
// cache tag and data storage
`timescale 1ns/1ps
`default_nettype none

module cache_way_array #(
    parameter int num_ways = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cache_pkg::tag_t              req_tag,
    input  cache_pkg::index_t            req_index,
    input  cache_pkg::offset_t           req_offset,
    input  cache_pkg::word_t             req_wdata,
    input  cache_pkg::size_t             req_size,
    input  logic [num_ways-1:0]          store_word,
    input  logic [num_ways-1:0]          fill_line,
    input  cache_pkg::line_t             fill_data,
    input  logic                         touch,
    output logic [num_ways-1:0]          way_hit,
    output logic [$clog2(num_ways)-1:0]  victim_way,
    output logic                         victim_dirty,
    output cache_pkg::tag_t              victim_tag,
    output cache_pkg::line_t             victim_line,
    output cache_pkg::word_t             rd_word
);
    import cache_pkg::*;

    localparam int way_w = $clog2(num_ways);

    tag_t                tag_mem  [num_ways][num_sets];
    line_t               data_mem [num_ways][num_sets];
    logic [num_ways-1:0] valid_q  [num_sets];
    logic [num_ways-1:0] dirty_q  [num_sets];
    logic [way_w-1:0]    age_q    [num_sets][num_ways];  // 0 = most recent

    logic [way_w-1:0] hit_way;
    line_t            hit_line;
    line_t            merged_line;
    logic             found_invalid;

    always_comb begin
        hit_way  = '0;
        hit_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = valid_q[req_index][w] && (tag_mem[w][req_index] == req_tag);
            if (way_hit[w]) begin
                hit_way  = way_w'(w);
                hit_line = data_mem[w][req_index];
            end
        end
    end

    // first invalid way wins, else the oldest one
    always_comb begin
        found_invalid = 1'b0;
        victim_way    = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (!found_invalid && !valid_q[req_index][w]) begin
                victim_way    = way_w'(w);
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid) begin
            for (int w = 0; w < num_ways; w++) begin
                if (age_q[req_index][w] == way_w'(num_ways - 1)) begin
                    victim_way = way_w'(w);
                end
            end
        end
    end

    assign victim_dirty = valid_q[req_index][victim_way] & dirty_q[req_index][victim_way];
    assign victim_tag   = tag_mem[victim_way][req_index];
    assign victim_line  = data_mem[victim_way][req_index];

    always_comb begin
        case (req_size)
            size_byte: rd_word = word_t'(hit_line[{req_offset, 3'b000} +: 8]);
            size_half: rd_word = word_t'(hit_line[{req_offset[3:1], 4'b0000} +: 16]);
            default:   rd_word = hit_line[{req_offset[3:2], 5'b00000} +: 32];
        endcase
    end

    always_comb begin
        merged_line = hit_line;
        case (req_size)
            size_byte: merged_line[{req_offset, 3'b000} +: 8] = req_wdata[7:0];
            size_half: merged_line[{req_offset[3:1], 4'b0000} +: 16] = req_wdata[15:0];
            default:   merged_line[{req_offset[3:2], 5'b00000} +: 32] = req_wdata;
        endcase
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (fill_line[w]) begin
                data_mem[w][req_index] <= fill_data;
                tag_mem[w][req_index]  <= req_tag;
            end else if (store_word[w]) begin
                data_mem[w][req_index] <= merged_line;  // byte lanes merged
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                for (int w = 0; w < num_ways; w++) begin
                    age_q[s][w] <= way_w'(num_ways - 1 - w);  // way 0 oldest
                end
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (fill_line[w]) begin
                    valid_q[req_index][w] <= 1'b1;
                    dirty_q[req_index][w] <= 1'b0;
                end else if (store_word[w]) begin
                    dirty_q[req_index][w] <= 1'b1;
                end
            end
            // accessed way becomes youngest, younger ones age by one
            if (touch) begin
                for (int w = 0; w < num_ways; w++) begin
                    if (way_w'(w) == hit_way) begin
                        age_q[req_index][w] <= '0;
                    end else if (age_q[req_index][w] < age_q[req_index][hit_way]) begin
                        age_q[req_index][w] <= age_q[req_index][w] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
// cache miss and hit sequencing
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int num_ways = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_start,
    input  logic                         req_write,
    input  logic [num_ways-1:0]          way_hit,
    input  logic [$clog2(num_ways)-1:0]  victim_way,
    input  logic                         victim_dirty,
    input  logic                         wb_done,
    input  logic                         rd_done,
    output logic [num_ways-1:0]          store_word,
    output logic [num_ways-1:0]          fill_line,
    output logic                         touch,
    output logic                         wb_start,
    output logic                         rd_start,
    output logic                         req_clear,
    output logic                         cpu_done,
    output logic                         cpu_hit
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        refill,
        fill,
        access
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   miss_q;  // a refill happened for this request
    logic   hit;

    assign hit = |way_hit;

    always_comb begin
        state_nxt = state;
        wb_start  = 1'b0;
        rd_start  = 1'b0;
        case (state)
            idle: begin
                if (req_start) begin
                    state_nxt = lookup;
                end
            end
            lookup: begin
                if (hit) begin
                    state_nxt = access;
                end else if (victim_dirty) begin
                    state_nxt = write_back;
                    wb_start  = 1'b1;
                end else begin
                    state_nxt = refill;
                    rd_start  = 1'b1;
                end
            end
            write_back: begin
                if (wb_done) begin
                    state_nxt = refill;
                    rd_start  = 1'b1;  // read follows write-back
                end
            end
            refill: begin
                if (rd_done) begin
                    state_nxt = fill;
                end
            end
            fill: begin
                state_nxt = access;  // filled way hits from here on
            end
            access: begin
                state_nxt = req_start ? lookup : idle;
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= idle;
            miss_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == lookup && !hit) begin
                miss_q <= 1'b1;
            end else if (req_start) begin
                miss_q <= 1'b0;
            end
        end
    end

    assign cpu_done   = (state == access);
    assign req_clear  = cpu_done;
    assign touch      = cpu_done;
    assign cpu_hit    = cpu_done & ~miss_q;
    assign store_word = (cpu_done && req_write) ? way_hit : '0;

    always_comb begin
        fill_line = '0;
        if (state == fill) begin
            fill_line[victim_way] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_port.sv
// memory side request levels
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_start,
    input  logic               rd_start,
    input  cache_pkg::tag_t    victim_tag,
    input  cache_pkg::line_t   victim_line,
    input  cache_pkg::tag_t    req_tag,
    input  cache_pkg::index_t  req_index,
    input  logic               mem_wb_ack,
    input  logic               mem_rd_ack,
    input  cache_pkg::line_t   mem_rd_line,
    output logic               mem_wb_req,
    output cache_pkg::addr_t   mem_wb_addr,
    output cache_pkg::line_t   mem_wb_line,
    output logic               mem_rd_req,
    output cache_pkg::addr_t   mem_rd_addr,
    output logic               wb_done,
    output logic               rd_done,
    output cache_pkg::line_t   fill_data
);
    import cache_pkg::*;

    // ack only counts while its request is up
    assign wb_done = mem_wb_req & mem_wb_ack;
    assign rd_done = mem_rd_req & mem_rd_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_req <= 1'b0;
            mem_rd_req <= 1'b0;
        end else begin
            if (wb_start) begin
                mem_wb_req <= 1'b1;
            end else if (wb_done) begin
                mem_wb_req <= 1'b0;
            end
            if (rd_start) begin
                mem_rd_req <= 1'b1;
            end else if (rd_done) begin
                mem_rd_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start) begin
            mem_wb_addr <= {victim_tag, req_index, offset_t'(0)};  // line aligned
            mem_wb_line <= victim_line;
        end
        if (rd_start) begin
            mem_rd_addr <= {req_tag, req_index, offset_t'(0)};
        end
        if (rd_done) begin
            fill_data <= mem_rd_line;
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_top.sv
// set-associative data cache
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int num_ways = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_valid,
    input  cache_pkg::addr_t   cpu_addr,
    input  cache_pkg::word_t   cpu_wdata,
    input  logic               cpu_write,
    input  cache_pkg::size_t   cpu_size,
    output logic               cpu_ready,
    output logic               cpu_done,
    output cache_pkg::word_t   cpu_rdata,
    output logic               cpu_hit,
    output logic               mem_wb_req,
    output cache_pkg::addr_t   mem_wb_addr,
    output cache_pkg::line_t   mem_wb_line,
    input  logic               mem_wb_ack,
    output logic               mem_rd_req,
    output cache_pkg::addr_t   mem_rd_addr,
    input  logic               mem_rd_ack,
    input  cache_pkg::line_t   mem_rd_line
);
    import cache_pkg::*;

    localparam int way_w = $clog2(num_ways);

    logic                req_start;
    logic                req_clear;
    tag_t                req_tag;
    index_t              req_index;
    offset_t             req_offset;
    word_t               req_wdata;
    logic                req_write;
    size_t               req_size;
    logic [num_ways-1:0] way_hit;
    logic [way_w-1:0]    victim_way;
    logic                victim_dirty;
    tag_t                victim_tag;
    line_t               victim_line;
    logic [num_ways-1:0] store_word;
    logic [num_ways-1:0] fill_line;
    line_t               fill_data;
    logic                touch;
    logic                wb_start;
    logic                rd_start;
    logic                wb_done;
    logic                rd_done;

    cpu_req_port u_req (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_valid  (cpu_valid),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_write  (cpu_write),
        .cpu_size   (cpu_size),
        .req_clear  (req_clear),
        .cpu_ready  (cpu_ready),
        .req_start  (req_start),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .req_offset (req_offset),
        .req_wdata  (req_wdata),
        .req_write  (req_write),
        .req_size   (req_size)
    );

    cache_way_array #(
        .num_ways (num_ways)
    ) u_ways (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_tag      (req_tag),
        .req_index    (req_index),
        .req_offset   (req_offset),
        .req_wdata    (req_wdata),
        .req_size     (req_size),
        .store_word   (store_word),
        .fill_line    (fill_line),
        .fill_data    (fill_data),
        .touch        (touch),
        .way_hit      (way_hit),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .rd_word      (cpu_rdata)
    );

    cache_ctrl #(
        .num_ways (num_ways)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_start    (req_start),
        .req_write    (req_write),
        .way_hit      (way_hit),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .wb_done      (wb_done),
        .rd_done      (rd_done),
        .store_word   (store_word),
        .fill_line    (fill_line),
        .touch        (touch),
        .wb_start     (wb_start),
        .rd_start     (rd_start),
        .req_clear    (req_clear),
        .cpu_done     (cpu_done),
        .cpu_hit      (cpu_hit)
    );

    mem_port u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_start    (wb_start),
        .rd_start    (rd_start),
        .victim_tag  (victim_tag),
        .victim_line (victim_line),
        .req_tag     (req_tag),
        .req_index   (req_index),
        .mem_wb_ack  (mem_wb_ack),
        .mem_rd_ack  (mem_rd_ack),
        .mem_rd_line (mem_rd_line),
        .mem_wb_req  (mem_wb_req),
        .mem_wb_addr (mem_wb_addr),
        .mem_wb_line (mem_wb_line),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .wb_done     (wb_done),
        .rd_done     (rd_done),
        .fill_data   (fill_data)
    );

endmodule

`default_nettype wire

// File: bench/mem_model.sv
// line-wide memory model
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_req,
    input  cache_pkg::addr_t  wb_addr,
    input  cache_pkg::line_t  wb_line,
    output logic              wb_ack,
    input  logic              rd_req,
    input  cache_pkg::addr_t  rd_addr,
    output logic              rd_ack,
    output cache_pkg::line_t  rd_line
);
    import cache_pkg::*;

    line_t lines [addr_t];  // written-back lines by line address
    int    wb_left;         // wait cycles still to go, -1 when no delay drawn
    int    rd_left;
    int    wb_now;
    int    rd_now;

    // every byte depends on the whole address
    function automatic logic [7:0] pattern_byte(addr_t a);
        word_t h;
        h = a * 32'h9e37_79b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic line_t pattern_line(addr_t base);
        line_t l;
        for (int i = 0; i < line_bytes; i++) begin
            l[i*8 +: 8] = pattern_byte(base + addr_t'(i));
        end
        return l;
    endfunction

    initial begin
        wb_ack  <= 1'b0;
        rd_ack  <= 1'b0;
        rd_line <= '0;
    end

    // ack after 1 to 6 cycles of a held request
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack  <= 1'b0;
            rd_ack  <= 1'b0;
            rd_line <= '0;
            wb_left <= -1;
            rd_left <= -1;
        end else begin
            wb_ack <= 1'b0;
            rd_ack <= 1'b0;
            if (wb_req && !wb_ack) begin
                wb_now = (wb_left < 0) ? int'($urandom % 6) : wb_left;
                if (wb_now == 0) begin
                    wb_ack  <= 1'b1;
                    wb_left <= -1;
                    lines[wb_addr] = wb_line;
                end else begin
                    wb_left <= wb_now - 1;
                end
            end
            if (rd_req && !rd_ack) begin
                rd_now = (rd_left < 0) ? int'($urandom % 6) : rd_left;
                if (rd_now == 0) begin
                    rd_ack  <= 1'b1;
                    rd_left <= -1;
                    rd_line <= lines.exists(rd_addr) ? lines[rd_addr] : pattern_line(rd_addr);
                end else begin
                    rd_left <= rd_now - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_cache_top.sv
// data cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;
    import cache_pkg::*;

    localparam int ways         = 2;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int num_directed = 19;
    localparam int num_random   = 40;
    localparam int watchdog_ns  =
        (reset_cycles + (num_directed + num_random) * 40) * clk_period;

    localparam addr_t addr_a = 32'h0000_0450;  // tags 1, 2 and 3 in set 5
    localparam addr_t addr_b = 32'h0000_0850;
    localparam addr_t addr_c = 32'h0000_0c50;

    logic  clk;
    logic  rst_n;
    logic  cpu_valid;
    addr_t cpu_addr;
    word_t cpu_wdata;
    logic  cpu_write;
    size_t cpu_size;
    logic  cpu_ready;
    logic  cpu_done;
    word_t cpu_rdata;
    logic  cpu_hit;
    logic  mem_wb_req;
    addr_t mem_wb_addr;
    line_t mem_wb_line;
    logic  mem_wb_ack;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    logic  mem_rd_ack;
    line_t mem_rd_line;
    logic  in_flight;

    logic [7:0] shadow [addr_t];        // bytes written by the CPU
    tag_t       res_tag   [num_sets][ways];  // slot 0 is the most recent
    logic       res_valid [num_sets][ways];
    logic       res_dirty [num_sets][ways];

    cache_top #(
        .num_ways (ways)
    ) u_cache_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_valid   (cpu_valid),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_write   (cpu_write),
        .cpu_size    (cpu_size),
        .cpu_ready   (cpu_ready),
        .cpu_done    (cpu_done),
        .cpu_rdata   (cpu_rdata),
        .cpu_hit     (cpu_hit),
        .mem_wb_req  (mem_wb_req),
        .mem_wb_addr (mem_wb_addr),
        .mem_wb_line (mem_wb_line),
        .mem_wb_ack  (mem_wb_ack),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_ack  (mem_rd_ack),
        .mem_rd_line (mem_rd_line)
    );

    mem_model u_mem_model (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (mem_wb_req),
        .wb_addr (mem_wb_addr),
        .wb_line (mem_wb_line),
        .wb_ack  (mem_wb_ack),
        .rd_req  (mem_rd_req),
        .rd_addr (mem_rd_addr),
        .rd_ack  (mem_rd_ack),
        .rd_line (mem_rd_line)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_equal(input string name, input line_t got, input line_t exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    // same fill pattern as the memory model
    function automatic logic [7:0] pattern_byte(addr_t a);
        word_t h;
        h = a * 32'h9e37_79b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [7:0] shadow_byte(addr_t a);
        return shadow.exists(a) ? shadow[a] : pattern_byte(a);
    endfunction

    function automatic line_t shadow_line(addr_t base);
        line_t l;
        for (int i = 0; i < line_bytes; i++) begin
            l[i*8 +: 8] = shadow_byte(base + addr_t'(i));
        end
        return l;
    endfunction

    function automatic int size_bytes(size_t sz);
        case (sz)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // little endian, zero extended
    function automatic word_t read_expect(addr_t a, size_t sz);
        word_t w;
        w = '0;
        for (int i = 0; i < size_bytes(sz); i++) begin
            w[i*8 +: 8] = shadow_byte(a + addr_t'(i));
        end
        return w;
    endfunction

    // tags kept in recency order, the last slot is the victim
    task automatic predict_access(input addr_t a, input logic wr, output logic hit,
                                  output logic wb, output addr_t wb_addr);
        tag_t   t;
        index_t s;
        int     pos;
        tag_t   mv_tag;
        logic   mv_dirty;
        t   = a[31:10];
        s   = a[9:4];
        pos = ways;
        for (int p = 0; p < ways; p++) begin
            if (res_valid[s][p] && res_tag[s][p] == t) begin
                pos = p;
            end
        end
        hit     = (pos != ways);
        wb      = 1'b0;
        wb_addr = '0;
        if (!hit) begin
            pos     = ways - 1;
            wb      = res_valid[s][pos] && res_dirty[s][pos];
            wb_addr = {res_tag[s][pos], s, 4'h0};
            res_tag[s][pos]   = t;
            res_valid[s][pos] = 1'b1;
            res_dirty[s][pos] = 1'b0;
        end
        mv_tag   = res_tag[s][pos];
        mv_dirty = res_dirty[s][pos] | wr;
        for (int p = pos; p > 0; p--) begin
            res_tag[s][p]   = res_tag[s][p-1];
            res_valid[s][p] = res_valid[s][p-1];
            res_dirty[s][p] = res_dirty[s][p-1];
        end
        res_tag[s][0]   = mv_tag;
        res_valid[s][0] = 1'b1;
        res_dirty[s][0] = mv_dirty;
    endtask

    task automatic run_access(input addr_t a, input word_t wd, input logic wr, input size_t sz);
        logic  exp_hit;
        logic  exp_wb;
        addr_t exp_wb_addr;
        line_t exp_wb_line;
        word_t exp_rdata;
        int    cycles;
        logic  saw_wb;
        logic  saw_rd;
        exp_rdata = read_expect(a, sz);
        predict_access(a, wr, exp_hit, exp_wb, exp_wb_addr);
        exp_wb_line = shadow_line(exp_wb_addr);
        if (wr) begin
            for (int i = 0; i < size_bytes(sz); i++) begin
                shadow[a + addr_t'(i)] = wd[i*8 +: 8];
            end
        end
        saw_wb = 1'b0;
        saw_rd = 1'b0;
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_addr  <= a;
        cpu_wdata <= wd;
        cpu_write <= wr;
        cpu_size  <= sz;
        @(negedge clk);
        check_equal("cpu_ready", line_t'(cpu_ready), line_t'(1'b1));
        @(posedge clk);
        cpu_valid <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!cpu_done) begin
            if (mem_wb_req && !saw_wb) begin
                saw_wb = 1'b1;
                check_equal("mem_wb_addr", line_t'(mem_wb_addr), line_t'(exp_wb_addr));
                check_equal("mem_wb_line", mem_wb_line, exp_wb_line);
            end
            if (mem_rd_req && !saw_rd) begin
                saw_rd = 1'b1;
                check_equal("mem_rd_addr", line_t'(mem_rd_addr), line_t'({a[31:4], 4'h0}));
            end
            @(negedge clk);
            cycles++;
        end
        check_equal("cpu_hit", line_t'(cpu_hit), line_t'(exp_hit));
        check_equal("mem_wb_req", line_t'(saw_wb), line_t'(exp_wb));
        check_equal("mem_rd_req", line_t'(saw_rd), line_t'(!exp_hit));
        if (!wr) begin
            check_equal("cpu_rdata", line_t'(cpu_rdata), line_t'(exp_rdata));
        end
        if (exp_hit) begin
            check_equal("hit latency", line_t'(cycles), line_t'(2));
        end
    endtask

    // request levels and their payload hold until the ack
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_wb_req && !mem_wb_ack) |=>
            (mem_wb_req && $stable(mem_wb_addr) && $stable(mem_wb_line)))
    else begin
        $display("ERR mem_wb_req %h mem_wb_addr %h changed before ack", mem_wb_req, mem_wb_addr);
        report_failure();
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_rd_req && !mem_rd_ack) |=> (mem_rd_req && $stable(mem_rd_addr)))
    else begin
        $display("ERR mem_rd_req %h mem_rd_addr %h changed before ack", mem_rd_req, mem_rd_addr);
        report_failure();
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_wb_req && mem_rd_req))
    else begin
        $display("ERR mem_wb_req %h mem_rd_req %h overlap", mem_wb_req, mem_rd_req);
        report_failure();
    end

    // ready is low after valid and high again with done
    always @(negedge clk) begin
        if (!rst_n) begin
            in_flight = 1'b0;
        end else begin
            if (in_flight && !cpu_done) begin
                assert (!cpu_ready) else begin
                    $display("ERR cpu_ready %h while a request is in flight", cpu_ready);
                    report_failure();
                end
            end
            if (cpu_done) begin
                assert (cpu_ready) else begin
                    $display("ERR cpu_ready %h low in the done cycle", cpu_ready);
                    report_failure();
                end
                in_flight = 1'b0;
            end
            if (cpu_valid) begin
                in_flight = 1'b1;
            end
        end
    end

    initial begin
        addr_t   a;
        size_t   sz;
        offset_t off;
        clk = 1'b0;
        void'($urandom(32'hc6d5));
        rst_n     <= 1'b0;
        cpu_valid <= 1'b0;
        cpu_addr  <= '0;
        cpu_wdata <= '0;
        cpu_write <= 1'b0;
        cpu_size  <= size_word;
        for (int s = 0; s < num_sets; s++) begin
            for (int p = 0; p < ways; p++) begin
                res_tag[s][p]   = '0;
                res_valid[s][p] = 1'b0;
                res_dirty[s][p] = 1'b0;
            end
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal("cpu_ready", line_t'(cpu_ready), line_t'(1'b1));
        check_equal("cpu_done", line_t'(cpu_done), line_t'(1'b0));
        check_equal("mem_wb_req", line_t'(mem_wb_req), line_t'(1'b0));
        check_equal("mem_rd_req", line_t'(mem_rd_req), line_t'(1'b0));

        run_access(addr_a, '0, 1'b0, size_word);  // cold miss
        run_access(addr_a, '0, 1'b0, size_word);  // hit
        run_access(addr_a + 32'd1, 32'h0000_00ab, 1'b1, size_byte);
        run_access(addr_a + 32'd6, 32'h0000_1234, 1'b1, size_half);
        run_access(addr_a + 32'd8, 32'hdead_beef, 1'b1, size_word);
        run_access(addr_a + 32'd1, '0, 1'b0, size_byte);
        run_access(addr_a + 32'd6, '0, 1'b0, size_half);
        run_access(addr_a + 32'd8, '0, 1'b0, size_word);
        run_access(addr_a + 32'd4, '0, 1'b0, size_word);
        run_access(addr_a, '0, 1'b0, size_word);
        run_access(addr_b, '0, 1'b0, size_word);  // second way
        run_access(addr_a, '0, 1'b0, size_word);
        run_access(addr_c, '0, 1'b0, size_word);  // B is the LRU line
        run_access(addr_a, '0, 1'b0, size_word);
        run_access(addr_c + 32'd4, 32'h5a5a_0001, 1'b1, size_word);
        run_access(addr_a, '0, 1'b0, size_word);
        run_access(addr_b, '0, 1'b0, size_word);  // dirty C written back
        run_access(addr_c + 32'd4, '0, 1'b0, size_word);
        run_access(addr_a + 32'd8, '0, 1'b0, size_word);

        // mixed traffic over two sets and four tags
        for (int n = 0; n < num_random; n++) begin
            sz  = size_t'($urandom % 3);
            off = offset_t'($urandom);
            if (sz == size_half) begin
                off[0] = 1'b0;
            end else if (sz == size_word) begin
                off[1:0] = 2'b00;
            end
            a = {tag_t'(1 + $urandom % 4), index_t'(5 + $urandom % 2), off};
            run_access(a, word_t'($urandom), 1'($urandom % 2), sz);
        end

        $display("All checks passed");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns without finishing", watchdog_ns);
        report_failure();
    end

endmodule

`default_nettype wire

// File: sources.f
hw/cache_pkg.sv
hw/cpu_req_port.sv
hw/cache_way_array.sv
hw/cache_ctrl.sv
hw/mem_port.sv
hw/cache_top.sv
bench/mem_model.sv
bench/tb_cache_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_cache_top -Mdir obj_dir -o sim_cache -f sources.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_cache 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
